// File: Bender.yml
package:
  name: core_pipeline

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/core_pkg.sv
      - hw/regfile.sv
      - hw/decode_stage.sv
      - hw/forward.sv
      - hw/execute_stage.sv
      - hw/mem_wb_stage.sv
      - hw/core_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/core_tb.sv

// File: bench/core_tb.sv
// Pipeline testbench: clock, reset, program, Wishbone memory model, reference model, assertions.
`include "core_config.svh"

module core_tb import core_pkg::*; ();

  localparam int MEM_WORDS    = 256;
  localparam int ACCEPT_LIMIT = 100;
  localparam int DRAIN_LIMIT  = 200;

  typedef struct packed {
    logic  we;
    word_t adr;
    word_t dat;
  } mem_op_t;

  logic       clk = 1'b0;
  logic       arst_n;
  logic       instr_valid;
  word_t      instr;
  logic       instr_ready;
  logic       wb_cyc;
  logic       wb_stb;
  logic       wb_we;
  word_t      wb_adr;
  word_t      wb_dat_o;
  logic [3:0] wb_sel;
  word_t      wb_dat_i;
  logic       wb_ack;
  logic       retire_valid;
  reg_addr_t  retire_rd;
  word_t      retire_data;

  word_t   ref_regs [`CORE_NREGS];
  word_t   ref_mem [MEM_WORDS];
  word_t   mem [MEM_WORDS];
  reg_wr_t exp_retire [$];
  mem_op_t exp_mem [$];
  reg_wr_t exp_rec;
  logic    first_accept = 1'b0;

  core_top uut (.*);

  always #10 clk = ~clk;

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    assert (actual === expected)
      else fail_run($sformatf("error t=%0t %s expected %0h got %0h",
                              $time, name, expected, actual));
  endtask

  function automatic word_t fill_word(input int unsigned idx);
    logic [7:0] a;
    a = idx[7:0];
    return {8'hc3, a, ~a, a ^ 8'h5a};  // Differs for every word address.
  endfunction

  function automatic word_t sext(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  task automatic expect_retire(input reg_addr_t rd, input word_t data);
    reg_wr_t rec;
    rec.en   = 1'b1;
    rec.rd   = rd;
    rec.data = data;
    exp_retire.push_back(rec);
    if (rd != '0) begin
      ref_regs[rd] = data;
    end
  endtask

  // Presents one instruction and waits until the core takes it.
  task automatic issue(input word_t word, input bit after_load);
    int unsigned gap;
    int unsigned waited;
    logic        taken;
    gap = (after_load || $urandom_range(0, 2) != 0) ? 0 : $urandom_range(1, 3);
    repeat (gap) begin
      instr = $urandom;  // Ignored while invalid.
      @(posedge clk);
      #2;
    end
    instr_valid = 1'b1;
    instr       = word;
    taken       = 1'b0;
    waited      = 0;
    while (!taken) begin
      @(negedge clk);
      taken = instr_ready;
      @(posedge clk);
      #2;
      waited++;
      if (!taken && waited > ACCEPT_LIMIT) begin
        fail_run("timeout waiting for instr_ready");
      end
    end
    instr_valid  = 1'b0;
    first_accept = 1'b1;
    if (after_load) begin
      @(negedge clk);
      assert (!instr_ready)
        else fail_run("instr_ready stayed high during the load-use bubble");
      @(posedge clk);
      #2;
    end
  endtask

  task automatic op_reg(input alu_op_e op, input reg_addr_t rd, input reg_addr_t rs1,
                        input reg_addr_t rs2, input bit after_load);
    word_t      a;
    word_t      b;
    word_t      y;
    logic [6:0] f7;
    logic [2:0] f3;
    a  = ref_regs[rs1];
    b  = ref_regs[rs2];
    f7 = 7'h00;
    case (op)
      ALU_SUB: begin
        y  = a - b;
        f7 = 7'h20;
        f3 = 3'b000;
      end
      ALU_AND: begin
        y  = a & b;
        f3 = 3'b111;
      end
      ALU_OR: begin
        y  = a | b;
        f3 = 3'b110;
      end
      ALU_XOR: begin
        y  = a ^ b;
        f3 = 3'b100;
      end
      default: begin
        y  = a + b;
        f3 = 3'b000;
      end
    endcase
    expect_retire(rd, y);
    issue({f7, rs2, rs1, f3, rd, 7'b0110011}, after_load);
  endtask

  task automatic op_addi(input reg_addr_t rd, input reg_addr_t rs1, input logic [11:0] imm,
                         input bit after_load);
    expect_retire(rd, ref_regs[rs1] + sext(imm));
    issue({imm, rs1, 3'b000, rd, 7'b0010011}, after_load);
  endtask

  task automatic op_lw(input reg_addr_t rd, input reg_addr_t rs1, input logic [11:0] imm);
    mem_op_t op;
    op.we  = 1'b0;
    op.adr = ref_regs[rs1] + sext(imm);
    op.dat = '0;
    exp_mem.push_back(op);
    expect_retire(rd, ref_mem[op.adr[9:2]]);
    issue({imm, rs1, 3'b010, rd, 7'b0000011}, 1'b0);
  endtask

  task automatic op_sw(input reg_addr_t rs2, input reg_addr_t rs1, input logic [11:0] imm);
    mem_op_t op;
    op.we  = 1'b1;
    op.adr = ref_regs[rs1] + sext(imm);
    op.dat = ref_regs[rs2];
    exp_mem.push_back(op);
    ref_mem[op.adr[9:2]] = op.dat;
    expect_retire('0, '0);  // Stores retire on rd zero.
    issue({imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011}, 1'b0);
  endtask

  task automatic run_round();
    logic [11:0] base;
    logic [11:0] off_a;
    logic [11:0] off_b;
    base  = 12'($urandom_range(0, 127) * 4);
    off_a = 12'($urandom_range(0, 63) * 4);
    off_b = 12'($urandom_range(0, 63) * 4);
    op_addi(1, 0, base, 1'b0);
    op_addi(2, 0, 12'($urandom), 1'b0);
    op_reg(ALU_ADD, 3, 1, 2, 1'b0);   // x2 at distance one, x1 at two.
    op_reg(ALU_SUB, 4, 3, 1, 1'b0);   // x1 at distance three.
    op_reg(ALU_XOR, 5, 4, 3, 1'b0);
    op_addi(5, 5, 12'($urandom), 1'b0);
    op_reg(ALU_OR, 7, 5, 4, 1'b0);    // Newer x5 must win over older x5.
    op_reg(ALU_AND, 8, 7, 2, 1'b0);
    op_sw(8, 1, off_a);               // Store data forwarded.
    op_lw(9, 1, off_a);
    op_reg(ALU_ADD, 10, 9, 3, 1'b1);  // Load-use on rs1.
    op_addi(0, 10, 12'($urandom), 1'b0);
    op_reg(ALU_ADD, 11, 0, 10, 1'b0); // x0 right after its write.
    op_sw(11, 1, off_b);
    op_lw(12, 1, off_b);
    op_reg(ALU_XOR, 13, 1, 12, 1'b1); // Load-use on rs2.
    op_lw(14, 1, off_a);
    op_addi(15, 14, 12'($urandom), 1'b1);
    op_reg(ALU_ADD, 0, 13, 15, 1'b0);
    op_reg(ALU_SUB, 16, 15, 0, 1'b0);
    op_reg(ALU_OR, 17, 0, 0, 1'b0);
    op_lw(18, 1, off_b + 12'd4);
  endtask

  // Wishbone classic slave with 0 to 3 wait cycles.
  initial begin : wb_slave
    int unsigned delay;
    mem_op_t     exp_op;
    wb_ack   = 1'b0;
    wb_dat_i = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = fill_word(i);
    end
    forever begin
      @(posedge clk);
      #2;
      if (arst_n && wb_cyc && wb_stb) begin
        delay = $urandom_range(0, 3);
        repeat (delay) begin
          @(posedge clk);
          #2;
        end
        assert (exp_mem.size() > 0)
          else fail_run("Wishbone cycle with no load or store outstanding");
        exp_op = exp_mem.pop_front();
        check_value("wb_we", word_t'(exp_op.we), word_t'(wb_we));
        check_value("wb_adr", exp_op.adr, wb_adr);
        if (exp_op.we) begin
          check_value("wb_dat_o", exp_op.dat, wb_dat_o);
          mem[wb_adr[9:2]] = wb_dat_o;
        end else begin
          wb_dat_i = mem[wb_adr[9:2]];
        end
        wb_ack = 1'b1;
        @(posedge clk);
        #2;
        wb_ack = 1'b0;
      end
    end
  end

  always @(negedge clk) begin
    if (arst_n && retire_valid) begin
      assert (exp_retire.size() > 0)
        else fail_run("retire seen with no instruction outstanding");
      exp_rec = exp_retire.pop_front();
      check_value("retire_rd", word_t'(exp_rec.rd), word_t'(retire_rd));
      if (exp_rec.rd != '0) begin
        check_value("retire_data", exp_rec.data, retire_data);
      end
    end
  end

  always @(negedge clk) begin
    if (!first_accept) begin
      assert (!wb_cyc && !wb_stb && !retire_valid)
        else fail_run("bus cycle or retire before the first instruction was accepted");
    end
  end

  a_stb_with_cyc: assert property (@(posedge clk) disable iff (!arst_n) wb_stb |-> wb_cyc)
    else fail_run("wb_stb high without wb_cyc");

  a_sel_full: assert property (@(posedge clk) disable iff (!arst_n) wb_cyc |-> wb_sel == 4'hf)
    else fail_run("wb_sel not all ones during a cycle");

  a_hold_until_ack: assert property (@(posedge clk) disable iff (!arst_n)
    (wb_stb && !wb_ack) |=> wb_cyc && wb_stb && $stable(wb_adr) && $stable(wb_we) &&
                            $stable(wb_dat_o))
    else fail_run("Wishbone request changed or dropped before ack");

  a_drop_after_ack: assert property (@(posedge clk) disable iff (!arst_n)
    (wb_stb && wb_ack) |=> !wb_cyc && !wb_stb)
    else fail_run("wb_cyc or wb_stb still high after ack");

  initial begin
    int unsigned waited;
    void'($urandom(32'headd_df86));
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    for (int i = 0; i < `CORE_NREGS; i++) begin
      ref_regs[i] = '0;
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = fill_word(i);
    end
    repeat (16) @(posedge clk);
    #2;
    arst_n = 1'b1;
    @(negedge clk);
    assert (!instr_ready) else fail_run("instr_ready high in the first cycle after reset");
    @(posedge clk);
    #2;
    repeat (4) run_round();
    waited = 0;
    while ((exp_retire.size() != 0 || exp_mem.size() != 0) && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (exp_retire.size() == 0 && exp_mem.size() == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      fail_run("timeout waiting for outstanding instructions to retire");
    end
  end

endmodule

// File: hw/core_config.svh
// Core width macros: data word, register address and register count.
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Data and address word width.
`define CORE_XLEN 32

// Register index width.
`define CORE_RADDR_W 5

// Number of integer registers, x0 included.
`define CORE_NREGS 32

`endif

// File: hw/core_pkg.sv
// Core types: word and register index vectors, ALU and bus state enums, stage bundles.
`include "core_config.svh"

package core_pkg;

  typedef logic [`CORE_XLEN-1:0]    word_t;
  typedef logic [`CORE_RADDR_W-1:0] reg_addr_t;
  typedef logic [1:0]               wb_src_t;

  localparam int WB_EXE = 0;  // ALU result to register.
  localparam int WB_MEM = 1;  // Load data to register.

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } alu_op_e;

  typedef enum logic {
    IDLE,
    BUSY
  } mem_state_e;

  typedef struct packed {
    logic      valid;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     op1;
    word_t     op2;
    word_t     imm;
    logic      use_imm;
    alu_op_e   alu_op;
    wb_src_t   wb_src;
    logic      is_load;
    logic      is_store;
  } id_ex_t;

  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    wb_src_t   wb_src;
    logic      is_load;
    logic      is_store;
    word_t     alu;
    word_t     store_data;
  } ex_mem_t;

  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    wb_src_t   wb_src;
    word_t     alu;
    word_t     load_data;
  } mem_wb_t;

  typedef struct packed {
    logic      en;
    reg_addr_t rd;
    word_t     data;
  } reg_wr_t;

endpackage

// File: hw/core_top.sv
// Core top level: decode, execute and memory/writeback stages with the retire port.
module core_top import core_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       instr_valid,
  input  word_t      instr,
  output logic       instr_ready,
  output logic       wb_cyc,
  output logic       wb_stb,
  output logic       wb_we,
  output word_t      wb_adr,
  output word_t      wb_dat_o,
  output logic [3:0] wb_sel,
  input  word_t      wb_dat_i,
  input  logic       wb_ack,
  output logic       retire_valid,
  output reg_addr_t  retire_rd,
  output word_t      retire_data
);

  id_ex_t    id_ex;
  ex_mem_t   ex_mem;
  mem_wb_t   mem_wb;
  reg_wr_t   reg_wr;
  reg_addr_t ex_load_rd;
  logic      mem_stall;

  decode_stage u_decode (.hold(mem_stall), .*);

  execute_stage u_execute (.hold(mem_stall), .*);

  mem_wb_stage u_mem_wb (.*);

  assign retire_valid = reg_wr.en;
  assign retire_rd    = reg_wr.rd;
  assign retire_data  = reg_wr.data;

endmodule

// File: hw/decode_stage.sv
// Decode stage: instruction intake, RV32I subset decode, register read, load-use bubble.
module decode_stage import core_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      instr_valid,
  input  word_t     instr,
  output logic      instr_ready,
  input  logic      hold,
  input  reg_addr_t ex_load_rd,
  input  reg_wr_t   reg_wr,
  output id_ex_t    id_ex
);

  localparam logic [6:0] OPC_REG   = 7'b0110011;
  localparam logic [6:0] OPC_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  word_t     instr_q;
  logic      instr_q_valid;
  logic      started;
  logic      known;
  logic      use_rs1;
  logic      use_rs2;
  logic      load_use;
  reg_addr_t rs1;
  reg_addr_t rs2;
  word_t     rd1;
  word_t     rd2;
  id_ex_t    dec;

  assign rs1 = instr_q[19:15];
  assign rs2 = instr_q[24:20];

  regfile u_regfile (.clk, .arst_n, .rs1, .rs2, .rd1, .rd2, .wr(reg_wr));

  always_comb begin
    dec     = '0;
    dec.rd  = instr_q[11:7];
    dec.imm = {{20{instr_q[31]}}, instr_q[31:20]};
    known   = 1'b0;
    use_rs1 = 1'b1;
    use_rs2 = 1'b0;
    case (instr_q[6:0])
      OPC_REG: begin
        known              = 1'b1;
        use_rs2            = 1'b1;
        dec.wb_src[WB_EXE] = 1'b1;
        case ({instr_q[31:25], instr_q[14:12]})
          10'b0000000_000: dec.alu_op = ALU_ADD;
          10'b0100000_000: dec.alu_op = ALU_SUB;
          10'b0000000_100: dec.alu_op = ALU_XOR;
          10'b0000000_110: dec.alu_op = ALU_OR;
          10'b0000000_111: dec.alu_op = ALU_AND;
          default:         known = 1'b0;
        endcase
      end
      OPC_IMM: begin
        known              = (instr_q[14:12] == 3'b000);  // ADDI only.
        dec.use_imm        = 1'b1;
        dec.wb_src[WB_EXE] = 1'b1;
      end
      OPC_LOAD: begin
        known              = (instr_q[14:12] == 3'b010);  // LW only.
        dec.use_imm        = 1'b1;
        dec.is_load        = 1'b1;
        dec.wb_src[WB_MEM] = 1'b1;
      end
      OPC_STORE: begin
        known        = (instr_q[14:12] == 3'b010);  // SW only.
        use_rs2      = 1'b1;
        dec.use_imm  = 1'b1;
        dec.is_store = 1'b1;
        dec.rd       = '0;
        dec.imm      = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
      end
      default: use_rs1 = 1'b0;
    endcase
    dec.rs1   = use_rs1 ? rs1 : '0;
    dec.rs2   = use_rs2 ? rs2 : '0;
    dec.op1   = rd1;
    dec.op2   = rd2;
    dec.valid = instr_q_valid && known;  // Unknown opcodes leave as bubbles.
  end

  assign load_use = instr_q_valid && (ex_load_rd != '0) &&
                    ((use_rs1 && rs1 == ex_load_rd) || (use_rs2 && rs2 == ex_load_rd));

  assign instr_ready = started && !hold && !load_use;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      started       <= 1'b0;
      instr_q_valid <= 1'b0;
      id_ex         <= '0;
    end else begin
      started <= 1'b1;
      if (!hold) begin
        if (load_use) begin
          id_ex.valid <= 1'b0;  // Bubble, instruction stays.
        end else begin
          id_ex         <= dec;
          instr_q_valid <= instr_valid && instr_ready;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (instr_valid && instr_ready) begin
      instr_q <= instr;
    end
  end

endmodule

// File: hw/execute_stage.sv
// Execute stage: ALU, operand forwarding and the execute-to-memory latch.
module execute_stage import core_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      hold,
  input  id_ex_t    id_ex,
  input  mem_wb_t   mem_wb,
  output reg_addr_t ex_load_rd,
  output ex_mem_t   ex_mem
);

  word_t op1;
  word_t op2;
  word_t now_op1;
  word_t now_op2;
  word_t op1_q;
  word_t op2_q;
  word_t alu_b;
  word_t alu_y;
  logic  held;

  // The writeback producer leaves during a stall, so operands are kept locally.
  assign now_op1 = held ? op1_q : id_ex.op1;
  assign now_op2 = held ? op2_q : id_ex.op2;

  forward u_forward (
    .rs1(id_ex.rs1),
    .rs2(id_ex.rs2),
    .ex_mem,
    .mem_wb,
    .now_op1,
    .now_op2,
    .op1,
    .op2
  );

  assign alu_b = id_ex.use_imm ? id_ex.imm : op2;

  always_comb begin
    case (id_ex.alu_op)
      ALU_SUB: alu_y = op1 - alu_b;
      ALU_AND: alu_y = op1 & alu_b;
      ALU_OR:  alu_y = op1 | alu_b;
      ALU_XOR: alu_y = op1 ^ alu_b;
      default: alu_y = op1 + alu_b;  // Also load and store addresses.
    endcase
  end

  assign ex_load_rd = (id_ex.valid && id_ex.is_load) ? id_ex.rd : '0;

  always_ff @(posedge clk) begin
    if (hold) begin
      op1_q <= op1;
      op2_q <= op2;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      held   <= 1'b0;
      ex_mem <= '0;
    end else begin
      held <= hold;
      if (!hold) begin
        ex_mem.valid      <= id_ex.valid;
        ex_mem.rd         <= id_ex.rd;
        ex_mem.wb_src     <= id_ex.wb_src;
        ex_mem.is_load    <= id_ex.is_load;
        ex_mem.is_store   <= id_ex.is_store;
        ex_mem.alu        <= alu_y;
        ex_mem.store_data <= op2;
      end
    end
  end

endmodule

// File: hw/forward.sv
// Operand forwarding from the memory-stage ALU result and the writeback-stage results.
module forward import core_pkg::*; (
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  ex_mem_t   ex_mem,
  input  mem_wb_t   mem_wb,
  input  word_t     now_op1,
  input  word_t     now_op2,
  output word_t     op1,
  output word_t     op2
);

  function automatic word_t pick(reg_addr_t rs, word_t now_val, ex_mem_t mem, mem_wb_t wb);
    logic mem_hit;
    logic wb_hit;
    mem_hit = mem.valid && (rs != '0) && (mem.rd == rs);
    wb_hit  = wb.valid && (rs != '0) && (wb.rd == rs);
    if (mem_hit && mem.wb_src[WB_EXE]) begin
      return mem.alu;
    end else if (wb_hit && wb.wb_src[WB_EXE]) begin
      return wb.alu;
    end else if (wb_hit && wb.wb_src[WB_MEM]) begin
      return wb.load_data;
    end
    return now_val;
  endfunction

  // Writeback-stage control is used for both operands.
  always_comb begin
    op1 = pick(rs1, now_op1, ex_mem, mem_wb);
    op2 = pick(rs2, now_op2, ex_mem, mem_wb);
  end

endmodule

// File: hw/mem_wb_stage.sv
// Memory and writeback stage: Wishbone classic master, writeback latch and register write.
module mem_wb_stage import core_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  ex_mem_t    ex_mem,
  output logic       mem_stall,
  output mem_wb_t    mem_wb,
  output reg_wr_t    reg_wr,
  output logic       wb_cyc,
  output logic       wb_stb,
  output logic       wb_we,
  output word_t      wb_adr,
  output word_t      wb_dat_o,
  output logic [3:0] wb_sel,
  input  word_t      wb_dat_i,
  input  logic       wb_ack
);

  mem_state_e state;
  logic       mem_req;
  logic       done;

  assign mem_req   = ex_mem.valid && (ex_mem.is_load || ex_mem.is_store);
  assign done      = (state == BUSY) && wb_ack;
  assign mem_stall = mem_req && !done;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (mem_req) state <= BUSY;
        BUSY:    if (wb_ack) state <= IDLE;  // Cycle drops after ack.
        default: state <= IDLE;
      endcase
    end
  end

  // Address and data come straight from the held latch.
  assign wb_cyc   = (state == BUSY);
  assign wb_stb   = (state == BUSY);
  assign wb_we    = ex_mem.is_store;
  assign wb_adr   = ex_mem.alu;
  assign wb_dat_o = ex_mem.store_data;
  assign wb_sel   = 4'hf;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mem_wb <= '0;
    end else begin
      mem_wb.valid     <= ex_mem.valid && !mem_stall;  // Bubble while waiting.
      mem_wb.rd        <= ex_mem.rd;
      mem_wb.wb_src    <= ex_mem.wb_src;
      mem_wb.alu       <= ex_mem.alu;
      mem_wb.load_data <= wb_dat_i;
    end
  end

  always_comb begin
    reg_wr.en   = mem_wb.valid;
    reg_wr.rd   = mem_wb.rd;
    reg_wr.data = mem_wb.wb_src[WB_MEM] ? mem_wb.load_data : mem_wb.alu;
  end

  a_stb_needs_cyc: assert property (@(posedge clk) disable iff (!arst_n)
    wb_stb |-> wb_cyc && mem_req);

  a_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
    (wb_stb && !wb_ack) |=> wb_stb && $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_o));

endmodule

// File: hw/regfile.sv
// Register file with two asynchronous read ports, one write port, write-through and zero x0.
`include "core_config.svh"

module regfile import core_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  output word_t     rd1,
  output word_t     rd2,
  input  reg_wr_t   wr
);

  word_t regs [`CORE_NREGS];
  logic  wr_live;

  assign wr_live = wr.en && (wr.rd != '0);  // x0 is never written.

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `CORE_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[wr.rd] <= wr.data;
    end
  end

  assign rd1 = (wr_live && wr.rd == rs1) ? wr.data : regs[rs1];  // Write-through.
  assign rd2 = (wr_live && wr.rd == rs2) ? wr.data : regs[rs2];

  a_x0_reads_zero: assert property (@(posedge clk) disable iff (!arst_n)
    (rs1 != '0 || rd1 == '0) && (rs2 != '0 || rd2 == '0));

endmodule

// File: verilog.f
+incdir+hw
hw/core_pkg.sv
hw/regfile.sv
hw/decode_stage.sv
hw/forward.sv
hw/execute_stage.sv
hw/mem_wb_stage.sv
hw/core_top.sv
bench/core_tb.sv
